/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src/icache_ctrl.sv */
module icache_ctrl #(
    parameter int SETS = 16,
    parameter int WAYS = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int OFF_W = $clog2($bits(icache_pkg::line_t) / 8),
    localparam int TAG_W = icache_pkg::ADDR_W - OFF_W - SET_W
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  icache_pkg::fetch_req_t             req,
    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output icache_pkg::fetch_rsp_t             rsp,
    input  logic                               invalidate,
    output logic                               ar_valid,
    input  logic                               ar_ready,
    output icache_pkg::axi_ar_t                ar,
    input  logic                               r_valid,
    output logic                               r_ready,
    input  icache_pkg::axi_r_t                 r,
    output logic                               rd_en,
    output logic [SET_W-1:0]                   rd_set,
    output logic [SET_W-1:0]                   wr_set,
    output logic [TAG_W-1:0]                   wr_tag,
    output icache_pkg::line_t                  wr_line,
    output logic [WAYS-1:0]                    wr_en,
    output logic                               clr_all,
    input  logic [WAYS-1:0]                    way_valid,
    input  logic [WAYS-1:0][TAG_W-1:0]         way_tag,
    input  icache_pkg::line_t [WAYS-1:0]       way_line,
    output logic                               hit_upd,
    output logic                               fill_upd,
    output logic [SET_W-1:0]                   upd_set,
    output logic [WAY_W-1:0]                   upd_way,
    output logic [SET_W-1:0]                   victim_set,
    input  logic [WAY_W-1:0]                   victim_way
);

    localparam int BEAT_W = $clog2(icache_pkg::LINE_WORDS);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::fetch_req_t  req_q;
    icache_pkg::fetch_rsp_t  rsp_q;
    icache_pkg::line_t       line_q;
    icache_pkg::line_t       fill_line;
    logic [BEAT_W-1:0]       beat_q;
    logic [WAY_W-1:0]        vict_q;
    logic [WAY_W-1:0]        hit_way;
    logic [WAYS-1:0]         hit_vec;
    logic [SET_W-1:0]        req_set;
    logic [TAG_W-1:0]        req_tag;
    logic                    hit;
    logic                    inv_pend_q;
    logic                    inv_req;
    logic                    refill_last;

    function automatic icache_pkg::blk_t pick_half(input icache_pkg::line_t ln, input logic hi);
        return hi ? ln[icache_pkg::LINE_WORDS-1:icache_pkg::BLK_WORDS]
                  : ln[icache_pkg::BLK_WORDS-1:0];
    endfunction

    assign req_set = req_q.addr[OFF_W +: SET_W];
    assign req_tag = req_q.addr[OFF_W+SET_W +: TAG_W];

    // An invalidate waits for IDLE and blocks new requests in the cycle it is taken.
    assign inv_req   = invalidate | inv_pend_q;
    assign req_ready = (state_q == icache_pkg::IDLE) && !inv_req;
    assign clr_all   = (state_q == icache_pkg::IDLE) && inv_req;
    assign rd_en     = req_valid & req_ready;
    assign rd_set    = req.addr[OFF_W +: SET_W];

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            hit_vec[i] = way_valid[i] && (way_tag[i] == req_tag);
            if (hit_vec[i]) begin
                hit_way = WAY_W'(i);
            end
        end
    end

    assign hit         = |hit_vec;
    assign refill_last = (state_q == icache_pkg::REFILL) && r_valid && r.last;

    // The beat arriving now is merged so the last beat can be written straight away.
    always_comb begin
        fill_line         = line_q;
        fill_line[beat_q] = r.data;
    end

    assign wr_set  = req_set;
    assign wr_tag  = req_tag;
    assign wr_line = fill_line;
    assign wr_en   = refill_last ? (WAYS'(1) << vict_q) : '0;

    assign hit_upd    = (state_q == icache_pkg::LOOKUP) && hit;
    assign fill_upd   = refill_last;
    assign upd_set    = req_set;
    assign upd_way    = (state_q == icache_pkg::LOOKUP) ? hit_way : vict_q;
    assign victim_set = req_set;

    always_comb begin
        ar.addr  = {req_q.addr[icache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        ar.len   = 8'(icache_pkg::LINE_WORDS - 1);
        ar.size  = 3'd2;    // Four bytes per beat.
        ar.burst = 2'b01;   // INCR.
    end

    assign ar_valid  = (state_q == icache_pkg::MISS);
    assign r_ready   = (state_q == icache_pkg::REFILL);
    assign rsp_valid = (state_q == icache_pkg::RESPOND);
    assign rsp       = rsp_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= icache_pkg::IDLE;
            inv_pend_q <= 1'b0;
            beat_q     <= '0;
        end else begin
            inv_pend_q <= inv_req && (state_q != icache_pkg::IDLE);
            case (state_q)
                icache_pkg::IDLE: begin
                    if (rd_en) begin
                        state_q <= icache_pkg::LOOKUP;
                    end
                end
                icache_pkg::LOOKUP: begin
                    state_q <= hit ? icache_pkg::RESPOND : icache_pkg::MISS;
                end
                icache_pkg::MISS: begin
                    if (ar_ready) begin
                        state_q <= icache_pkg::REFILL;
                        beat_q  <= '0;
                    end
                end
                icache_pkg::REFILL: begin
                    if (r_valid) begin
                        beat_q <= beat_q + 1'b1;
                        if (r.last) begin
                            state_q <= icache_pkg::RESPOND;
                        end
                    end
                end
                icache_pkg::RESPOND: begin
                    if (rsp_ready) begin
                        state_q <= icache_pkg::IDLE;
                    end
                end
                default: state_q <= icache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            req_q <= req;
        end
        if ((state_q == icache_pkg::LOOKUP) && !hit) begin
            vict_q <= victim_way;   // Held so the fill lands in the way picked at lookup.
        end
        if ((state_q == icache_pkg::REFILL) && r_valid) begin
            line_q <= fill_line;
        end
        if (hit_upd || refill_last) begin
            rsp_q.tag_id <= req_q.tag_id;
            rsp_q.data   <= pick_half(hit_upd ? way_line[hit_way] : fill_line,
                                      req_q.addr[OFF_W-1]);
        end
    end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_WORDS = 8;
    localparam int BLK_WORDS = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef word_t [LINE_WORDS-1:0] line_t;
    typedef word_t [BLK_WORDS-1:0] blk_t;

    typedef struct packed {
        addr_t      addr;    // Byte address of a four-word block.
        logic [3:0] tag_id;
    } fetch_req_t;

    typedef struct packed {
        logic [3:0] tag_id;
        blk_t       data;
    } fetch_rsp_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

/* src/icache_plru.sv */
module icache_plru #(
    parameter int SETS = 16,
    parameter int WAYS = 4,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             hit_upd,
    input  logic             fill_upd,
    input  logic [SET_W-1:0] upd_set,
    input  logic [WAY_W-1:0] upd_way,
    input  logic [SET_W-1:0] victim_set,
    output logic [WAY_W-1:0] victim_way
);

    logic [SETS-1:0][WAYS-2:0] tree_q;   // Heap order, node n has children 2n+1 and 2n+2.

    // Walk the path of the touched way and point every node away from it.
    function automatic logic [WAYS-2:0] touch(input logic [WAYS-2:0] row,
                                              input logic [WAY_W-1:0] way);
        logic [WAYS-2:0] nxt;
        int              node;
        nxt  = row;
        node = 0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            nxt[node] = ~way[WAY_W-1-lvl];
            node      = 2 * node + 1 + int'(way[WAY_W-1-lvl]);
        end
        return nxt;
    endfunction

    function automatic logic [WAY_W-1:0] pick(input logic [WAYS-2:0] row);
        logic [WAY_W-1:0] way;
        int               node;
        node = 0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            way[WAY_W-1-lvl] = row[node];    // A zero bit sends the search left.
            node             = 2 * node + 1 + int'(row[node]);
        end
        return way;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;
        end else if (hit_upd || fill_upd) begin
            tree_q[upd_set] <= touch(tree_q[upd_set], upd_way);
        end
    end

    assign victim_way = pick(tree_q[victim_set]);

endmodule

/* src/icache_top.sv */
module icache_top #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  icache_pkg::fetch_req_t req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   invalidate,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output icache_pkg::axi_ar_t    ar,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  icache_pkg::axi_r_t     r
);

    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int OFF_W = $clog2($bits(icache_pkg::line_t) / 8);
    localparam int TAG_W = icache_pkg::ADDR_W - OFF_W - SET_W;

    logic                         rd_en;
    logic [SET_W-1:0]             rd_set;
    logic [SET_W-1:0]             wr_set;
    logic [TAG_W-1:0]             wr_tag;
    icache_pkg::line_t            wr_line;
    logic [WAYS-1:0]              wr_en;
    logic                         clr_all;
    logic [WAYS-1:0]              way_valid;
    logic [WAYS-1:0][TAG_W-1:0]   way_tag;
    icache_pkg::line_t [WAYS-1:0] way_line;
    logic                         hit_upd;
    logic                         fill_upd;
    logic [SET_W-1:0]             upd_set;
    logic [WAY_W-1:0]             upd_way;
    logic [SET_W-1:0]             victim_set;
    logic [WAY_W-1:0]             victim_way;

    icache_ctrl #(
        .SETS(SETS),
        .WAYS(WAYS)
    ) u_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp(rsp),
        .invalidate(invalidate),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar(ar),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .r(r),
        .rd_en(rd_en),
        .rd_set(rd_set),
        .wr_set(wr_set),
        .wr_tag(wr_tag),
        .wr_line(wr_line),
        .wr_en(wr_en),
        .clr_all(clr_all),
        .way_valid(way_valid),
        .way_tag(way_tag),
        .way_line(way_line),
        .hit_upd(hit_upd),
        .fill_upd(fill_upd),
        .upd_set(upd_set),
        .upd_way(upd_way),
        .victim_set(victim_set),
        .victim_way(victim_way)
    );

    // All ways see the same read and write set, only the write enable differs.
    for (genvar i = 0; i < WAYS; i++) begin : g_way
        icache_way #(
            .SETS(SETS)
        ) u_way (
            .clk(clk),
            .arst_n(arst_n),
            .rd_en(rd_en),
            .rd_set(rd_set),
            .wr_en(wr_en[i]),
            .wr_set(wr_set),
            .wr_tag(wr_tag),
            .wr_line(wr_line),
            .clr_all(clr_all),
            .valid(way_valid[i]),
            .tag(way_tag[i]),
            .line(way_line[i])
        );
    end

    icache_plru #(
        .SETS(SETS),
        .WAYS(WAYS)
    ) u_plru (
        .clk(clk),
        .arst_n(arst_n),
        .hit_upd(hit_upd),
        .fill_upd(fill_upd),
        .upd_set(upd_set),
        .upd_way(upd_way),
        .victim_set(victim_set),
        .victim_way(victim_way)
    );

endmodule

/* src/icache_way.sv */
module icache_way #(
    parameter int SETS = 16,
    localparam int SET_W = $clog2(SETS),
    localparam int OFF_W = $clog2($bits(icache_pkg::line_t) / 8),
    localparam int TAG_W = icache_pkg::ADDR_W - OFF_W - SET_W
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              rd_en,
    input  logic [SET_W-1:0]  rd_set,
    input  logic              wr_en,
    input  logic [SET_W-1:0]  wr_set,
    input  logic [TAG_W-1:0]  wr_tag,
    input  icache_pkg::line_t wr_line,
    input  logic              clr_all,
    output logic              valid,
    output logic [TAG_W-1:0]  tag,
    output icache_pkg::line_t line
);

    logic [SETS-1:0]   valid_q;
    logic [TAG_W-1:0]  tag_mem [SETS];
    icache_pkg::line_t data_mem [SETS];

    // Valid bits are the only state that must come up clean.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            valid   <= 1'b0;
        end else begin
            if (clr_all) begin
                valid_q <= '0;
            end else if (wr_en) begin
                valid_q[wr_set] <= 1'b1;
            end
            if (rd_en) begin
                valid <= valid_q[rd_set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_set]  <= wr_tag;
            data_mem[wr_set] <= wr_line;   // A fill always writes the whole line.
        end
        if (rd_en) begin
            tag  <= tag_mem[rd_set];
            line <= data_mem[rd_set];
        end
    end

endmodule

/* tb.f */
src/icache_pkg.sv
src/icache_way.sv
src/icache_plru.sv
src/icache_ctrl.sv
src/icache_top.sv
tests/tb_clk_gen.sv
tests/tb_axi_mem.sv
tests/tb_icache.sv

/* tests/tb_axi_mem.sv */
module tb_axi_mem (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  icache_pkg::axi_ar_t ar,
    output logic                r_valid,
    input  logic                r_ready,
    output icache_pkg::axi_r_t  r,
    output int                  ar_count,
    output icache_pkg::axi_ar_t last_ar
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                active;
    logic [2:0]          beat;
    icache_pkg::addr_t   base;
    icache_pkg::axi_ar_t ar_q;
    logic                ar_hs;
    logic                r_hs;

    // Memory contents are a fixed scramble of the word address.
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t wa);
        return (wa * 32'h9E3779B1) ^ 32'hC0DE0000;
    endfunction

    // Handshakes seen during a cycle are applied just after the edge that completes them.
    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        ar_count = 0;
        last_ar  = '0;
        active   = 1'b0;
        beat     = '0;
        base     = '0;
        ar_q     = '0;
        ar_hs    = 1'b0;
        r_hs     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!arst_n) begin
                ar_ready = 1'b0;
                r_valid  = 1'b0;
                active   = 1'b0;
                ar_hs    = 1'b0;
                r_hs     = 1'b0;
            end else begin
                if (ar_hs) begin
                    ar_count++;
                    last_ar = ar_q;
                    active  = 1'b1;
                    beat    = '0;
                    base    = ar_q.addr >> 2;
                end
                if (r_hs) begin
                    if (r.last) begin
                        active = 1'b0;
                    end
                    beat = beat + 3'd1;
                end
                ar_ready = !active && !stall;
                if (!(r_valid && !r_hs)) begin   // A beat on offer stays until taken.
                    if (active && !stall) begin
                        r_valid = 1'b1;
                        r.data  = mem_word(base + beat);
                        r.resp  = 2'b00;
                        r.last  = (beat == 3'd7);
                    end else begin
                        r_valid = 1'b0;
                    end
                end
                ar_hs = ar_valid && ar_ready;
                if (ar_hs) begin
                    ar_q = ar;
                end
                r_hs = r_valid && r_ready;
            end
        end
    end

endmodule

/* tests/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int HALF_NS      = 2,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;   // Released just after an edge like every other input.
    end

endmodule

/* tests/tb_icache.sv */
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_NS  = 4;
    localparam logic [31:0] SEED    = 32'h39789509;
    localparam int          NUM_REQ = 8 + 16 + 20 + 8 + 24 + 300;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    logic                   req_ready;
    icache_pkg::fetch_req_t req;
    logic                   rsp_valid;
    logic                   rsp_ready;
    icache_pkg::fetch_rsp_t rsp;
    logic                   invalidate;
    logic                   ar_valid;
    logic                   ar_ready;
    icache_pkg::axi_ar_t    ar;
    logic                   r_valid;
    logic                   r_ready;
    icache_pkg::axi_r_t     r;
    int                     ar_count;
    icache_pkg::axi_ar_t    last_ar;
    logic                   mem_stall = 1'b0;
    logic [31:0]            rnd_q = SEED;
    logic [31:0]            gap_q = SEED;
    logic                   bp_en = 1'b0;
    int                     exp_ar_count = 0;
    logic [3:0]             m_valid [16];
    logic [22:0]            m_tag [16][4];
    logic [2:0]             m_tree [16];

    tb_clk_gen u_clk_gen (
        .clk(clk),
        .arst_n(arst_n)
    );

    tb_axi_mem u_mem (
        .clk(clk),
        .arst_n(arst_n),
        .stall(mem_stall),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar(ar),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .r(r),
        .ar_count(ar_count),
        .last_ar(last_ar)
    );

    icache_top #(
        .SETS(16),
        .WAYS(4)
    ) u_icache_top (
        .clk(clk),
        .arst_n(arst_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req(req),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp(rsp),
        .invalidate(invalidate),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar(ar),
        .r_valid(r_valid),
        .r_ready(r_ready),
        .r(r)
    );

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_q = lfsr_next(rnd_q);
            v     = {v[30:0], rnd_q[0]};
        end
        return v;
    endfunction

    always @(posedge clk) begin
        gap_q = lfsr_next(gap_q);
        mem_stall <= gap_q[0];   // Gaps before ar_ready and between R beats.
    end

    function automatic icache_pkg::addr_t blk_addr(input int tag, input int set_idx,
                                                   input logic hi);
        return icache_pkg::addr_t'((tag << 9) | (set_idx << 5) | (int'(hi) << 4));
    endfunction

    function automatic icache_pkg::blk_t ref_block(input icache_pkg::addr_t addr);
        icache_pkg::blk_t  blk;
        icache_pkg::word_t wa;
        for (int i = 0; i < 4; i++) begin
            wa     = (addr >> 2) + i;
            blk[i] = (wa * 32'h9E3779B1) ^ 32'hC0DE0000;
        end
        return blk;
    endfunction

    // Four ways, tree bit 0 is the root, bit 1 covers ways 0/1 and bit 2 covers ways 2/3.
    function automatic logic ref_plru(input icache_pkg::addr_t addr);
        int          idx;
        int          way;
        logic [22:0] tg;
        logic        miss;
        idx = int'(addr[8:5]);
        tg  = addr[31:9];
        way = -1;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            if (!m_tree[idx][0]) begin
                way = m_tree[idx][1] ? 1 : 0;
            end else begin
                way = m_tree[idx][2] ? 3 : 2;
            end
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tg;
        end
        m_tree[idx][0] = (way < 2);
        if (way < 2) begin
            m_tree[idx][1] = (way == 0);
        end else begin
            m_tree[idx][2] = (way == 2);
        end
        return miss;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_rsp(input string name, input icache_pkg::fetch_rsp_t exp,
                             input icache_pkg::fetch_rsp_t act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ar(input string name, input icache_pkg::axi_ar_t exp,
                            input icache_pkg::axi_ar_t act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(input string name, input icache_pkg::addr_t addr, input logic [3:0] id);
        icache_pkg::fetch_rsp_t exp;
        icache_pkg::fetch_rsp_t first;
        icache_pkg::axi_ar_t    exp_ar;
        logic                   miss;
        logic                   accepted;
        logic                   got;
        logic                   hs;
        int                     lat;
        miss = ref_plru(addr);
        if (miss) begin
            exp_ar_count++;
        end
        exp.tag_id   = id;
        exp.data     = ref_block(addr);
        exp_ar.addr  = {addr[31:5], 5'b0};
        exp_ar.len   = 8'd7;
        exp_ar.size  = 3'd2;
        exp_ar.burst = 2'b01;
        req.addr     = addr;
        req.tag_id   = id;
        req_valid    = 1'b1;
        accepted     = 1'b0;
        while (!accepted) begin
            accepted = req_ready;
            step();
        end
        req_valid = 1'b0;
        lat       = 1;   // The acceptance cycle is cycle zero.
        got       = 1'b0;
        hs        = 1'b0;
        while (!hs) begin
            rsp_ready = bp_en ? (rand_bits(1) != 0) : 1'b1;
            if (rsp_valid) begin
                if (!got) begin
                    got   = 1'b1;
                    first = rsp;
                    check_rsp(name, exp, rsp);
                    if (!miss) begin
                        check_count({name, " latency"}, 2, lat);
                    end
                end else begin
                    check_rsp({name, " held"}, first, rsp);
                end
                if (req_ready) begin
                    report_failure({name, ": req_ready was high while a response waited."});
                end
                hs = rsp_ready;
            end
            step();
            lat++;
        end
        check_count({name, " ar count"}, exp_ar_count, ar_count);
        if (miss) begin
            check_ar({name, " ar"}, exp_ar, last_ar);
        end
    endtask

    task automatic pulse_invalidate();
        invalidate = 1'b1;
        #1;
        if (req_ready) begin
            report_failure("req_ready was high in the cycle an invalidate was taken.");
        end
        step();
        invalidate = 1'b0;
        step();
        for (int s = 0; s < 16; s++) begin
            m_valid[s] = '0;
        end
    endtask

    // Every offered read beat must find the cache ready.
    always @(negedge clk) begin
        if (arst_n && r_valid && !r_ready) begin
            report_failure("r_ready was low while a read beat was offered.");
        end
    end

    initial begin
        #((NUM_REQ * 200 + 100) * CLK_NS);
        report_failure("Watchdog expired before all requests completed.");
    end

    initial begin
        int         tg;
        int         st;
        int         ar_base;
        logic       hi;
        logic [3:0] id;
        logic [5:0] idx;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        invalidate = 1'b0;
        for (int s = 0; s < 16; s++) begin
            m_valid[s] = '0;
            m_tree[s]  = '0;
        end
        @(posedge arst_n);
        step();
        if (!req_ready || rsp_valid || ar_valid || r_ready) begin
            report_failure("Handshake outputs were wrong after reset.");
        end

        for (int i = 0; i < 8; i++) begin
            fetch($sformatf("cold %0d", i), blk_addr(i + 1, i * 2, i[0]), 4'(i));
        end
        check_count("cold total", 8, ar_count);

        for (int i = 0; i < 16; i++) begin
            fetch($sformatf("hit %0d", i), blk_addr(i / 2 + 1, (i / 2) * 2, i[0]), 4'(i));
        end
        check_count("hit total", 8, ar_count);

        for (int i = 0; i < 20; i++) begin
            tg = 100 + int'(rand_bits(3)) % 5;
            hi = rand_bits(1) != 0;
            fetch($sformatf("replace %0d", i), blk_addr(tg, 9, hi), 4'(i));
        end

        pulse_invalidate();
        ar_base = ar_count;
        for (int i = 0; i < 8; i++) begin
            fetch($sformatf("inval %0d", i), blk_addr(i + 1, i * 2, !i[0]), 4'(i));
        end
        check_count("inval total", ar_base + 8, ar_count);

        bp_en = 1'b1;
        for (int i = 0; i < 24; i++) begin
            tg = 300 + int'(rand_bits(2));
            st = int'(rand_bits(4));
            hi = rand_bits(1) != 0;
            fetch($sformatf("backpressure %0d", i), blk_addr(tg, st, hi), 4'(i));
        end
        bp_en = 1'b0;

        for (int i = 0; i < 300; i++) begin
            if (rand_bits(6) == 0) begin
                pulse_invalidate();
            end
            idx = 6'(rand_bits(6));
            hi  = rand_bits(1) != 0;
            id  = 4'(rand_bits(4));
            fetch($sformatf("mix %0d", i), blk_addr(500 + int'(idx[5:3]), int'(idx[2:0]), hi), id);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule
